// ==== Makefile ====
# Verilator build and run of the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= riscvSingleCycleTb
FILELIST  ?= riscvSingleCycle.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hdl/decodeIf.sv ====
`timescale 1ns/1ps

// decoded fields, all combinational from the current instr
interface decodeIf;
    import rvPkg::*;

    opcode_t  opcode;
    funct3_t  funct3;
    logic     funct7b5;  // SUB / SRA select
    regAddr_t rd;
    regAddr_t rs1;
    regAddr_t rs2;
    word_t    imm;       // already sign extended for the format
    logic     illegal;

    modport decoder (
        output opcode, funct3, funct7b5, rd, rs1, rs2, imm, illegal
    );

    modport exec (
        input opcode, funct3, funct7b5, rd, rs1, rs2, imm, illegal
    );

endinterface

// ==== hdl/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
    input rvPkg::word_t instr,
    decodeIf.decoder    dec
);
    import rvPkg::*;

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign dec.opcode   = opcode;
    assign dec.funct3   = funct3;
    assign dec.funct7b5 = instr[30];
    assign dec.rd       = instr[11:7];
    assign dec.rs1      = instr[19:15];
    assign dec.rs2      = instr[24:20];

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: dec.imm = immU;
            OP_JAL:           dec.imm = immJ;
            OP_BRANCH:        dec.imm = immB;
            OP_STORE:         dec.imm = immS;
            default:          dec.imm = immI;  // JALR, loads, OP-IMM
        endcase
    end

    // the only place legality is decided
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL: dec.illegal = 1'b0;
            OP_JALR:   dec.illegal = (funct3 != 3'b000);
            OP_BRANCH: dec.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
            OP_LOAD:   dec.illegal = (funct3 == 3'b011) || funct3[2:1] == 2'b11;
            OP_STORE:  dec.illegal = (funct3 > F3_SW);
            OP_IMM: begin
                if (funct3 == F3_SLL)
                    dec.illegal = (funct7 != 7'b0);
                else if (funct3 == F3_SRL)
                    dec.illegal = ({funct7[6], funct7[4:0]} != 6'b0);  // SRAI keeps bit 30
                else
                    dec.illegal = 1'b0;
            end
            OP_REG: begin
                if (funct3 == F3_ADD || funct3 == F3_SRL)
                    dec.illegal = ({funct7[6], funct7[4:0]} != 6'b0);
                else
                    dec.illegal = (funct7 != 7'b0);
            end
            default: dec.illegal = 1'b1;  // unknown, incl. FENCE and SYSTEM
        endcase
    end

endmodule

// ==== hdl/intAlu.sv ====
`timescale 1ns/1ps

module intAlu (
    decodeIf.exec        dec,
    input  rvPkg::word_t rs1Data,
    input  rvPkg::word_t rs2Data,
    output rvPkg::word_t result
);
    import rvPkg::*;

    word_t      opB;
    logic [4:0] shamt;
    logic       isSub;
    logic       lessSigned;
    logic       lessUnsigned;
    word_t      sraResult;

    assign opB   = (dec.opcode == OP_IMM) ? dec.imm : rs2Data;
    assign shamt = opB[4:0];

    // bit 30 is an immediate bit for ADDI, so SUB only exists in OP
    assign isSub = (dec.opcode == OP_REG) && dec.funct7b5;

    assign lessUnsigned = (rs1Data < opB);

    // signs differ -> the negative one is smaller
    assign lessSigned = (rs1Data[XLEN-1] != opB[XLEN-1]) ? rs1Data[XLEN-1] : lessUnsigned;

    // logical shift, then fill the vacated top bits with the sign
    assign sraResult = (rs1Data >> shamt) |
                       ({XLEN{rs1Data[XLEN-1]}} & ~({XLEN{1'b1}} >> shamt));

    always_comb begin
        case (dec.funct3)
            F3_ADD:  result = isSub ? rs1Data - opB : rs1Data + opB;
            F3_SLL:  result = rs1Data << shamt;
            F3_SLT:  result = {{(XLEN-1){1'b0}}, lessSigned};
            F3_SLTU: result = {{(XLEN-1){1'b0}}, lessUnsigned};
            F3_XOR:  result = rs1Data ^ opB;
            F3_SRL:  result = dec.funct7b5 ? sraResult : rs1Data >> shamt;  // SRA(I) on bit 30
            F3_OR:   result = rs1Data | opB;
            F3_AND:  result = rs1Data & opB;
            default: result = '0;
        endcase
    end

endmodule

// ==== hdl/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
    decodeIf.exec          dec,
    input  rvPkg::word_t   rs1Data,
    input  rvPkg::word_t   rs2Data,
    input  rvPkg::word_t   dataRead,
    output rvPkg::word_t   addr,
    output rvPkg::word_t   writeData,
    output rvPkg::byteEn_t byteEn,
    output rvPkg::word_t   loadData
);
    import rvPkg::*;

    logic [1:0] lane;
    word_t      shifted;

    assign addr = rs1Data + dec.imm;  // same sum for I and S immediates
    assign lane = addr[1:0];          // aligned access assumed

    // store side, data copied to every lane and the enables pick
    always_comb begin
        case (dec.funct3)
            F3_SB: begin
                writeData = {4{rs2Data[7:0]}};
                byteEn    = 4'b0001 << lane;
            end
            F3_SH: begin
                writeData = {2{rs2Data[15:0]}};
                byteEn    = lane[1] ? 4'b1100 : 4'b0011;
            end
            F3_SW: begin
                writeData = rs2Data;
                byteEn    = 4'b1111;
            end
            default: begin
                writeData = rs2Data;
                byteEn    = '0;
            end
        endcase
    end

    // load side
    assign shifted = dataRead >> {lane, 3'b000};  // addressed lane down to bit 0

    always_comb begin
        case (dec.funct3)
            F3_LB:   loadData = {{24{shifted[7]}}, shifted[7:0]};
            F3_LH:   loadData = {{16{shifted[15]}}, shifted[15:0]};
            F3_LW:   loadData = dataRead;
            F3_LBU:  loadData = {24'b0, shifted[7:0]};
            F3_LHU:  loadData = {16'b0, shifted[15:0]};
            default: loadData = '0;
        endcase
    end

endmodule

// ==== hdl/nextPcUnit.sv ====
`timescale 1ns/1ps

module nextPcUnit (
    decodeIf.exec        dec,
    input  rvPkg::word_t pc,
    input  rvPkg::word_t rs1Data,
    input  rvPkg::word_t rs2Data,
    output rvPkg::word_t pcNext,
    output rvPkg::word_t pcPlus4,
    output rvPkg::word_t pcPlusImm
);
    import rvPkg::*;

    logic  isEq;
    logic  ltUnsigned;
    logic  ltSigned;
    logic  taken;
    word_t jalrSum;

    assign pcPlus4   = pc + XLEN'(4);
    assign pcPlusImm = pc + dec.imm;  // branch/JAL target, AUIPC result
    assign jalrSum   = rs1Data + dec.imm;

    assign isEq       = (rs1Data == rs2Data);
    assign ltUnsigned = (rs1Data < rs2Data);
    assign ltSigned   = (rs1Data[XLEN-1] != rs2Data[XLEN-1]) ? rs1Data[XLEN-1] : ltUnsigned;

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  taken = isEq;
            F3_BNE:  taken = !isEq;
            F3_BLT:  taken = ltSigned;
            F3_BGE:  taken = !ltSigned;
            F3_BLTU: taken = ltUnsigned;
            F3_BGEU: taken = !ltUnsigned;
            default: taken = 1'b0;  // illegal funct3, flagged by decoder
        endcase
    end

    always_comb begin
        case (dec.opcode)
            OP_JAL:    pcNext = pcPlusImm;
            OP_JALR:   pcNext = {jalrSum[XLEN-1:1], 1'b0};
            OP_BRANCH: pcNext = taken ? pcPlusImm : pcPlus4;
            default:   pcNext = pcPlus4;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    output rvPkg::word_t    rs1Data,
    output rvPkg::word_t    rs2Data,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    rdData,
    input  logic            we
);
    import rvPkg::*;

    word_t regs [1:NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= rdData;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/riscvSingleCycle.sv ====
`timescale 1ns/1ps

module riscvSingleCycle (
    input  logic           clk,
    input  logic           rst,
    output rvPkg::word_t   instrAddr,
    input  rvPkg::word_t   instr,
    output rvPkg::word_t   dataAddr,
    output rvPkg::word_t   dataWrite,
    output rvPkg::byteEn_t dataByteEn,
    output logic           dataWe,
    input  rvPkg::word_t   dataRead,
    output logic           halt
);
    import rvPkg::*;

    word_t pc;
    word_t pcNext;
    word_t pcPlus4;
    word_t pcPlusImm;
    word_t rs1Data;
    word_t rs2Data;
    word_t aluResult;
    word_t loadData;
    word_t wbData;
    logic  writesRd;
    logic  rdWe;

    decodeIf dec ();

    instrDecode u_decode (.instr(instr), .dec(dec));

    regFile u_regs (
        .clk(clk), .rst(rst),
        .rs1(dec.rs1), .rs2(dec.rs2),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .rd(dec.rd), .rdData(wbData), .we(rdWe)
    );

    intAlu u_alu (.dec(dec), .rs1Data(rs1Data), .rs2Data(rs2Data), .result(aluResult));

    nextPcUnit u_npc (
        .dec(dec), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .pcNext(pcNext), .pcPlus4(pcPlus4), .pcPlusImm(pcPlusImm)
    );

    loadStoreUnit u_lsu (
        .dec(dec), .rs1Data(rs1Data), .rs2Data(rs2Data), .dataRead(dataRead),
        .addr(dataAddr), .writeData(dataWrite), .byteEn(dataByteEn), .loadData(loadData)
    );

    always_comb begin
        writesRd = 1'b1;
        case (dec.opcode)
            OP_REG, OP_IMM:  wbData = aluResult;
            OP_LOAD:         wbData = loadData;
            OP_JAL, OP_JALR: wbData = pcPlus4;  // link address
            OP_LUI:          wbData = dec.imm;
            OP_AUIPC:        wbData = pcPlusImm;
            default: begin
                wbData   = '0;
                writesRd = 1'b0;  // branches, stores, unknown
            end
        endcase
    end

    assign rdWe   = writesRd && !dec.illegal && !halt;
    assign dataWe = (dec.opcode == OP_STORE) && !dec.illegal && !halt && !rst;  // no write in reset

    assign instrAddr = pc;

    // halt is sticky, pc stays on the illegal word
    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= '0;
            halt <= 1'b0;
        end else if (!halt) begin
            halt <= dec.illegal;
            if (!dec.illegal)
                pc <= pcNext;
        end
    end

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]               word_t;    // data, address or instruction
    typedef logic [$clog2(NUM_REGS)-1:0]   regAddr_t;
    typedef logic [6:0]                    opcode_t;
    typedef logic [2:0]                    funct3_t;
    typedef logic [XLEN/8-1:0]             byteEn_t;  // one bit per byte lane

    // major opcodes, RV32I base set only
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // branch compares, 010 and 011 unused
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load widths, bit 2 means zero extend
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

    // shared by OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;  // also SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;  // also SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

endpackage

// ==== riscvSingleCycle.f ====
hdl/rvPkg.sv
hdl/decodeIf.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/intAlu.sv
hdl/nextPcUnit.sv
hdl/loadStoreUnit.sv
hdl/riscvSingleCycle.sv
tests/riscvSingleCycleTb.sv

// ==== tests/riscvSingleCycleTb.sv ====
`timescale 1ns/1ps

module riscvSingleCycleTb;
    import rvPkg::*;

    logic    clk;
    logic    rst;
    word_t   instrAddr;
    word_t   instr;
    word_t   dataAddr;
    word_t   dataWrite;
    byteEn_t dataByteEn;
    logic    dataWe;
    word_t   dataRead;
    logic    halt;

    int      seed = 29301;
    int      valueErrs;
    int      otherErrs;
    int      progIdx;
    int      stores;
    int      expCount;
    int      cycles;
    bit      abort;
    word_t   expPc;
    word_t   held;
    word_t   prog [0:63];   // program, zero words past the end
    word_t   dmem [0:63];   // 256-byte data region
    word_t   mmem [0:63];   // model copy
    word_t   expAddr [$];
    word_t   expData [$];
    byteEn_t expBe [$];
    funct3_t loadF3 [0:4]   = '{F3_LB, F3_LH, F3_LBU, F3_LHU, F3_LW};
    funct3_t branchF3 [0:5] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    riscvSingleCycle dut (
        .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWrite(dataWrite), .dataByteEn(dataByteEn),
        .dataWe(dataWe), .dataRead(dataRead), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic regAddr_t anyReg();
        return regAddr_t'(pick(8));  // x0..x7 so values get reused
    endfunction

    function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, funct3_t f3,
                                   regAddr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1, funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t encB(logic [12:0] off, regAddr_t rs2, regAddr_t rs1, funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1, funct3_t f3,
                                   regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t encJ(logic [20:0] off, regAddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic bit legalWord(input word_t w);
        funct3_t    f3 = w[14:12];
        logic [6:0] f7 = w[31:25];
        case (w[6:0])
            OP_LUI, OP_AUIPC, OP_JAL: return 1'b1;
            OP_JALR:   return f3 == 3'b000;
            OP_BRANCH: return f3 != 3'b010 && f3 != 3'b011;
            OP_LOAD:   return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            OP_STORE:  return f3 <= 3'b010;
            OP_IMM: begin
                if (f3 == 3'b001)
                    return f7 == 7'b0;
                if (f3 == 3'b101)
                    return f7 == 7'b0 || f7 == 7'b0100000;
                return 1'b1;
            end
            OP_REG: begin
                if (f3 == 3'b000 || f3 == 3'b101)
                    return f7 == 7'b0 || f7 == 7'b0100000;
                return f7 == 7'b0;
            end
            default: return 1'b0;
        endcase
    endfunction

    task automatic genProgram(input int p);
        int         i;
        int         off;
        int         sz;
        funct3_t    f3;
        regAddr_t   r1;
        regAddr_t   r2;
        logic [6:0] f7;
        logic [11:0] imm;
        for (i = 0; i < 64; i++)
            prog[i] = '0;
        prog[0] = {20'(pick(1 << 20)), regAddr_t'(1 + pick(7)), OP_LUI};  // never a store
        i = 1;
        while (i < 48) begin
            case (pick(10))
                0, 1: begin
                    f3  = funct3_t'(pick(8));
                    imm = 12'(pick(4096));
                    if (f3 == F3_SLL)
                        imm = {7'b0, 5'(pick(32))};
                    else if (f3 == F3_SRL)
                        imm = {(pick(2) != 0) ? 7'b0100000 : 7'b0, 5'(pick(32))};
                    prog[i] = encI(imm, anyReg(), f3, anyReg(), OP_IMM);
                end
                2, 3: begin
                    f3 = funct3_t'(pick(8));
                    f7 = ((f3 == F3_ADD || f3 == F3_SRL) && pick(2) != 0) ? 7'b0100000 : 7'b0;
                    prog[i] = encR(f7, anyReg(), anyReg(), f3, anyReg());
                end
                4: prog[i] = {20'(pick(1 << 20)), anyReg(), (pick(2) != 0) ? OP_LUI : OP_AUIPC};
                5: begin
                    sz  = pick(3);
                    off = pick(256) & ~((1 << sz) - 1);  // aligned to size
                    prog[i] = encS(12'(off), anyReg(), 5'd0, funct3_t'(sz));
                end
                6: begin
                    f3  = loadF3[pick(5)];
                    off = pick(256) & ~((1 << f3[1:0]) - 1);
                    prog[i] = encI(12'(off), 5'd0, f3, anyReg(), OP_LOAD);
                end
                7: prog[i] = encB(13'(4 * (1 + pick(4))), anyReg(), anyReg(), branchF3[pick(6)]);
                8: begin
                    if (pick(2) != 0)
                        prog[i] = encJ(21'(4 * (1 + pick(4))), anyReg());
                    else
                        prog[i] = encI(12'(4 * (i + 1 + pick(4))), 5'd0, F3_ADD, anyReg(),
                                       OP_JALR);
                end
                default: begin
                    if (i < 45) begin
                        // store a word, load part of it back, store the result
                        off = 4 * pick(64);
                        r1  = regAddr_t'(1 + pick(7));
                        r2  = regAddr_t'(1 + pick(7));
                        f3  = loadF3[pick(4)];
                        sz  = f3[0] ? 2 * pick(2) : pick(4);
                        prog[i]     = encS(12'(off), r1, 5'd0, F3_SW);
                        prog[i + 1] = encI(12'(off + sz), 5'd0, f3, r2, OP_LOAD);
                        prog[i + 2] = encS(12'(4 * pick(64)), r2, 5'd0, F3_SW);
                        i += 2;
                    end else begin
                        prog[i] = encI(12'(pick(4096)), anyReg(), F3_ADD, anyReg(), OP_IMM);
                    end
                end
            endcase
            i++;
        end
        if (p % 2 == 1) begin
            i = 8 + pick(32);  // illegal variant mid-program
            case (pick(5))
                0: prog[i] = encB(13'd8, anyReg(), anyReg(), funct3_t'(2 + pick(2)));
                1: prog[i] = encI(12'd0, 5'd0, (pick(2) != 0) ? 3'b011 : funct3_t'(6 + pick(2)),
                                  anyReg(), OP_LOAD);
                2: prog[i] = encS(12'd0, anyReg(), 5'd0, funct3_t'(3 + pick(5)));
                3: prog[i] = encR(7'b0000001, anyReg(), anyReg(), funct3_t'(pick(8)), anyReg());
                default: prog[i] = encI(12'd0, 5'd0, funct3_t'(1 + pick(7)), anyReg(), OP_JALR);
            endcase
        end
        for (i = 0; i < 64; i++)
            dmem[i] = (word_t'(i) * 32'h9e3779b1) ^ word_t'(p);
    endtask

    task automatic runModel();
        word_t    regs [0:31];
        word_t    pc;
        word_t    npc;
        word_t    w;
        word_t    a;
        word_t    b;
        word_t    res;
        word_t    addr;
        word_t    shifted;
        word_t    sdata;
        word_t    immI;
        word_t    immS;
        word_t    immB;
        word_t    immJ;
        funct3_t  f3;
        byteEn_t  be;
        logic     writes;
        logic     take;
        int       j;
        int       steps;
        for (j = 0; j < 32; j++)
            regs[j] = '0;
        mmem = dmem;
        expAddr.delete();
        expData.delete();
        expBe.delete();
        pc    = '0;
        steps = 0;
        while (steps < 200) begin
            w = (pc < 256) ? prog[pc[7:2]] : '0;
            if (!legalWord(w))
                break;
            f3   = w[14:12];
            a    = regs[w[19:15]];
            b    = regs[w[24:20]];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            npc    = pc + 4;
            writes = 1'b1;
            res    = '0;
            case (w[6:0])
                OP_LUI:   res = {w[31:12], 12'b0};
                OP_AUIPC: res = pc + {w[31:12], 12'b0};
                OP_JAL: begin
                    res = pc + 4;
                    npc = pc + immJ;
                end
                OP_JALR: begin
                    res = pc + 4;
                    npc = (a + immI) & ~32'd1;
                end
                OP_BRANCH: begin
                    writes = 1'b0;
                    case (f3)
                        3'b000:  take = a == b;
                        3'b001:  take = a != b;
                        3'b100:  take = $signed(a) < $signed(b);
                        3'b101:  take = $signed(a) >= $signed(b);
                        3'b110:  take = a < b;
                        default: take = a >= b;
                    endcase
                    if (take)
                        npc = pc + immB;
                end
                OP_LOAD: begin
                    addr    = a + immI;
                    shifted = mmem[addr[7:2]] >> (8 * addr[1:0]);
                    case (f3)
                        3'b000:  res = {{24{shifted[7]}}, shifted[7:0]};
                        3'b001:  res = {{16{shifted[15]}}, shifted[15:0]};
                        3'b100:  res = {24'b0, shifted[7:0]};
                        3'b101:  res = {16'b0, shifted[15:0]};
                        default: res = mmem[addr[7:2]];
                    endcase
                end
                OP_STORE: begin
                    writes = 1'b0;
                    addr   = a + immS;
                    case (f3)
                        3'b000: begin
                            be    = 4'b0001 << addr[1:0];
                            sdata = {4{b[7:0]}};
                        end
                        3'b001: begin
                            be    = 4'b0011 << addr[1:0];
                            sdata = {2{b[15:0]}};
                        end
                        default: begin
                            be    = 4'b1111;
                            sdata = b;
                        end
                    endcase
                    for (j = 0; j < 4; j++)
                        if (be[j])
                            mmem[addr[7:2]][8*j +: 8] = sdata[8*j +: 8];
                    expAddr.push_back(addr);
                    expData.push_back(sdata);
                    expBe.push_back(be);
                end
                default: begin  // OP and OP-IMM
                    if (w[6:0] == OP_IMM)
                        b = immI;
                    case (f3)
                        3'b000:  res = (w[6:0] == OP_REG && w[30]) ? a - b : a + b;
                        3'b001:  res = a << b[4:0];
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ b;
                        3'b101:  res = w[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
            endcase
            if (writes && w[11:7] != 5'd0)
                regs[w[11:7]] = res;
            pc = npc;
            steps++;
        end
        expPc    = pc;
        expCount = expAddr.size();
    endtask

    task automatic checkVal(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            valueErrs++;
            $display("** Error program %0d %s: expected %h, actual %h", progIdx, name, exp, act);
        end
    endtask

    // one cycle, inputs from the addresses seen after the falling edge
    task automatic stepCycle(input logic rstVal, input logic forceStore);
        @(negedge clk);
        rst = rstVal;
        if (rstVal || forceStore)
            instr = 32'h00002023;  // sw x0, 0(x0)
        else
            instr = (instrAddr < 256) ? prog[instrAddr[7:2]] : '0;
        #1;
        dataRead = dmem[dataAddr[7:2]];
        #0.5;
    endtask

    task automatic serveStore();
        word_t   ea;
        word_t   ed;
        word_t   mask;
        byteEn_t eb;
        int      j;
        if (!dataWe)
            return;
        stores++;
        if (expAddr.size() == 0) begin
            otherErrs++;
            $display("Program %0d made a store at pc %h that the model does not expect",
                     progIdx, instrAddr);
        end else begin
            ea = expAddr.pop_front();
            ed = expData.pop_front();
            eb = expBe.pop_front();
            for (j = 0; j < 4; j++)
                mask[8*j +: 8] = {8{eb[j]}};
            checkVal("store address", ea, dataAddr);
            checkVal("store byte enables", word_t'(eb), word_t'(dataByteEn));
            checkVal("store data", ed & mask, dataWrite & mask);
        end
        for (j = 0; j < 4; j++)
            if (dataByteEn[j])
                dmem[dataAddr[7:2]][8*j +: 8] = dataWrite[8*j +: 8];
    endtask

    initial begin
        rst       = 1'b1;
        instr     = '0;
        dataRead  = '0;
        valueErrs = 0;
        otherErrs = 0;
        abort     = 1'b0;
        for (progIdx = 0; progIdx < 20 && !abort; progIdx++) begin
            genProgram(progIdx);
            runModel();
            for (int r = 0; r < 8; r++) begin
                stepCycle(1'b1, 1'b0);
                checkVal("reset dataWe", 0, word_t'(dataWe));
                if (r > 0) begin  // first edge with rst not seen yet
                    checkVal("reset instrAddr", 0, instrAddr);
                    checkVal("reset halt", 0, word_t'(halt));
                end
            end
            stores = 0;
            cycles = 0;
            stepCycle(1'b0, 1'b0);
            checkVal("after reset instrAddr", 0, instrAddr);
            checkVal("after reset halt", 0, word_t'(halt));
            checkVal("after reset dataWe", 0, word_t'(dataWe));
            while (!halt && cycles < 400) begin
                serveStore();
                stepCycle(1'b0, 1'b0);
                cycles++;
            end
            if (!halt) begin
                otherErrs++;
                $display("Timeout: program %0d did not halt within 400 cycles", progIdx);
                abort = 1'b1;
            end else begin
                checkVal("halt pc", expPc, instrAddr);
                checkVal("store count", word_t'(expCount), word_t'(stores));
                held = instrAddr;
                repeat (10) begin
                    stepCycle(1'b0, 1'b1);
                    checkVal("sticky instrAddr", held, instrAddr);
                    checkVal("sticky dataWe", 0, word_t'(dataWe));
                    checkVal("sticky halt", 1, word_t'(halt));
                end
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        if (valueErrs + otherErrs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
